/* Makefile */
SRCS := $(filter-out +%,$(shell cat ber_top.f))

.PHONY: all run clean

all: run

obj_dir/Vtb_ber_top: ber_top.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_ber_top -f ber_top.f

run: obj_dir/Vtb_ber_top
	@out="$$(./obj_dir/Vtb_ber_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

/* ber_top.f */
verilog/ber_types_pkg.sv
verilog/ber_ctrl_pkg.sv
verilog/prbs9.sv
verilog/ber_window_timer.sv
verilog/ber_control.sv
verilog/ber_counter.sv
verilog/ber_top.sv
verification/ber_checker.sv
verification/tb_ber_top.sv

/* verification/ber_checker.sv */
module ber_checker (
  input  logic                  clk,
  input  logic                  i_check_idle,
  input  logic                  i_check_end,
  input  logic                  i_check_sync,
  input  int                    i_test_num,
  input  ber_types_pkg::accum_t i_exp_tot,
  input  ber_types_pkg::accum_t i_exp_err_i,
  input  ber_types_pkg::accum_t i_exp_err_q,
  input  ber_types_pkg::accum_t i_model_err_i,
  input  ber_types_pkg::accum_t i_model_err_q,
  input  ber_types_pkg::accum_t i_accum_err_i,
  input  ber_types_pkg::accum_t i_accum_tot_i,
  input  ber_types_pkg::accum_t i_accum_err_q,
  input  ber_types_pkg::accum_t i_accum_tot_q,
  input  logic                  i_ber_ok_i,
  input  logic                  i_ber_ok_q,
  input  logic                  i_synced,
  output int                    o_tests_run,
  output int                    o_tests_failed,
  output int                    o_check_errors
);
  timeunit 1ns;
  timeprecision 1ps;

  int   tests_run    = 0;
  int   tests_failed = 0;
  int   check_errors = 0;
  int   test_errors  = 0;
  logic sync_edge    = 1'b0;

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: test %0d %s = 0x%0h, expected 0x%0h", i_test_num, name, got, exp);
      test_errors++;
      check_errors++;
    end
  endtask

  task automatic compare_model(input string lane, input logic [63:0] model,
                               input logic [63:0] exp);
    if (model !== exp) begin
      $display("Test %0d: the transmitter injected %0d errors on lane %s, %s %0d",
               i_test_num, model, lane, "the stimulus file expects", exp);
      test_errors++;
      check_errors++;
    end
  endtask

  always @(posedge clk) begin
    // Before a measurement every output must be back at zero.
    if (i_check_idle) begin
      test_errors = 0;
      compare_value("o_accum_err_i", i_accum_err_i, '0);
      compare_value("o_accum_tot_i", i_accum_tot_i, '0);
      compare_value("o_accum_err_q", i_accum_err_q, '0);
      compare_value("o_accum_tot_q", i_accum_tot_q, '0);
      compare_value("o_ber_ok_i", 64'(i_ber_ok_i), '0);
      compare_value("o_ber_ok_q", 64'(i_ber_ok_q), '0);
      compare_value("o_synced", 64'(i_synced), '0);
    end
    // Lock shows on the cycle after the last sweep strobe and not before it.
    if (i_check_sync) begin
      compare_value("o_synced", 64'(i_synced), '0);
    end
    if (sync_edge) begin
      compare_value("o_synced", 64'(i_synced), 64'd1);
    end
    sync_edge = i_check_sync;
    if (i_check_end) begin
      compare_model("I", i_model_err_i, i_exp_err_i);
      compare_model("Q", i_model_err_q, i_exp_err_q);
      compare_value("o_accum_tot_i", i_accum_tot_i, i_exp_tot);
      compare_value("o_accum_tot_q", i_accum_tot_q, i_exp_tot);
      compare_value("o_accum_err_i", i_accum_err_i, i_exp_err_i);
      compare_value("o_accum_err_q", i_accum_err_q, i_exp_err_q);
      compare_value("o_ber_ok_i", 64'(i_ber_ok_i), 64'(i_exp_err_i == '0));
      compare_value("o_ber_ok_q", 64'(i_ber_ok_q), 64'(i_exp_err_q == '0));
      compare_value("o_synced", 64'(i_synced), 64'd1);
      tests_run++;
      if (test_errors == 0) begin
        $display("Test %0d: result ok, total 0x%0h, errors I 0x%0h Q 0x%0h",
                 i_test_num, i_accum_tot_i, i_accum_err_i, i_accum_err_q);
      end else begin
        tests_failed++;
        $display("Test %0d: result FAIL, %0d mismatches", i_test_num, test_errors);
      end
    end
  end

  assign o_tests_run    = tests_run;
  assign o_tests_failed = tests_failed;
  assign o_check_errors = check_errors;

endmodule

/* verification/ber_stimulus.txt */
// delay_i delay_q count_bits spacing_i spacing_q density exp_err_i exp_err_q
// All values hex. Spacing 0 sends no errors, density is strobes per four cycles.
000 000 1000 00 00  4 000 000
1FE 0A3 0800 00 00  4 000 000
07B 155 0C00 40 07  3 030 1B6
02D 1C0 0900 00 11  1 000 087
0FF 001 0600 01 100 2 600 006

/* verification/tb_ber_top.sv */
module tb_ber_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [8:0] SEED_I    = 9'h1AA;
  localparam logic [8:0] SEED_Q    = 9'h1FE;
  localparam int         PERIOD    = ber_types_pkg::PRBS_PERIOD;
  localparam int         SYNC_BITS = PERIOD * PERIOD;
  localparam int         COLS      = 8;
  localparam int         MAX_TESTS = 16;

  logic                  clk, i_rst_n, i_enable, i_en_rx, i_rx_bit_i, i_rx_bit_q;
  ber_types_pkg::accum_t o_accum_err_i, o_accum_tot_i, o_accum_err_q, o_accum_tot_q;
  logic                  o_ber_ok_i, o_ber_ok_q, o_synced;

  logic [31:0]           stim [0:COLS*MAX_TESTS-1];
  logic [PERIOD-1:0]     seq_i, seq_q;
  longint                limit_ns = 0;
  int                    num_tests, test_num, tests_run, tests_failed, check_errors;
  logic                  check_idle, check_end, check_sync;
  ber_types_pkg::accum_t exp_tot, exp_err_i, exp_err_q, model_err_i, model_err_q;

  ber_top #(
    .PRBS_SEED_I(SEED_I),
    .PRBS_SEED_Q(SEED_Q)
  ) DUT (
    .o_accum_err_i(o_accum_err_i),
    .o_accum_tot_i(o_accum_tot_i),
    .o_accum_err_q(o_accum_err_q),
    .o_accum_tot_q(o_accum_tot_q),
    .o_ber_ok_i   (o_ber_ok_i   ),
    .o_ber_ok_q   (o_ber_ok_q   ),
    .o_synced     (o_synced     ),
    .i_rx_bit_i   (i_rx_bit_i   ),
    .i_rx_bit_q   (i_rx_bit_q   ),
    .i_enable     (i_enable     ),
    .i_en_rx      (i_en_rx      ),
    .i_rst_n      (i_rst_n      ),
    .clk          (clk          )
  );

  ber_checker u_ber_checker (
    .clk           (clk          ),
    .i_check_idle  (check_idle   ),
    .i_check_end   (check_end    ),
    .i_check_sync  (check_sync   ),
    .i_test_num    (test_num     ),
    .i_exp_tot     (exp_tot      ),
    .i_exp_err_i   (exp_err_i    ),
    .i_exp_err_q   (exp_err_q    ),
    .i_model_err_i (model_err_i  ),
    .i_model_err_q (model_err_q  ),
    .i_accum_err_i (o_accum_err_i),
    .i_accum_tot_i (o_accum_tot_i),
    .i_accum_err_q (o_accum_err_q),
    .i_accum_tot_q (o_accum_tot_q),
    .i_ber_ok_i    (o_ber_ok_i   ),
    .i_ber_ok_q    (o_ber_ok_q   ),
    .i_synced      (o_synced     ),
    .o_tests_run   (tests_run    ),
    .o_tests_failed(tests_failed ),
    .o_check_errors(check_errors )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // One period of x^9 + x^5 + 1, index k being the bit sent on the k-th strobe.
  function automatic logic [PERIOD-1:0] prbs9_sequence(input logic [8:0] seed);
    logic [8:0]        lfsr;
    logic [PERIOD-1:0] seq;
    logic              fb;
    lfsr = seed;
    seq  = '0;
    for (int k = 0; k < PERIOD; k++) begin
      fb     = lfsr[8] ^ lfsr[4];
      seq[k] = fb;
      lfsr   = {lfsr[7:0], fb};
    end
    return seq;
  endfunction

  function automatic logic delayed_bit(input logic [PERIOD-1:0] seq, input int k, input int delay);
    int idx;
    idx = ((k % PERIOD) + PERIOD - delay) % PERIOD;
    return seq[idx];
  endfunction

  function automatic logic error_due(input int c, input int spacing);
    return (spacing != 0) && (((c + 1) % spacing) == 0);
  endfunction

  task automatic run_test(input int t);
    int   base, delay_i, delay_q, count_bits, spacing_i, spacing_q, density;
    int   k, err_i, err_q;
    logic bit_i, bit_q;
    base       = t * COLS;
    delay_i    = int'(stim[base]);
    delay_q    = int'(stim[base+1]);
    count_bits = int'(stim[base+2]);
    spacing_i  = int'(stim[base+3]);
    spacing_q  = int'(stim[base+4]);
    density    = int'(stim[base+5]);
    k          = 0;
    err_i      = 0;
    err_q      = 0;
    @(posedge clk);
    test_num   <= t + 1;
    exp_tot    <= ber_types_pkg::accum_t'(count_bits);
    exp_err_i  <= ber_types_pkg::accum_t'(stim[base+6]);
    exp_err_q  <= ber_types_pkg::accum_t'(stim[base+7]);
    check_idle <= 1'b1;
    @(posedge clk);
    check_idle <= 1'b0;
    i_enable   <= 1'b1;
    repeat (2) @(posedge clk);
    while (k < SYNC_BITS + count_bits) begin
      @(posedge clk);
      if (($urandom % 4) < density) begin
        bit_i = delayed_bit(seq_i, k, delay_i);
        bit_q = delayed_bit(seq_q, k, delay_q);
        // Errors go only into the counted part of the stream.
        if (k >= SYNC_BITS && error_due(k - SYNC_BITS, spacing_i)) begin
          bit_i = ~bit_i;
          err_i++;
        end
        if (k >= SYNC_BITS && error_due(k - SYNC_BITS, spacing_q)) begin
          bit_q = ~bit_q;
          err_q++;
        end
        i_en_rx    <= 1'b1;
        i_rx_bit_i <= bit_i;
        i_rx_bit_q <= bit_q;
        // Marks the strobe that closes the last window of the sweep.
        check_sync <= (k == SYNC_BITS - 1);
        k++;
      end else begin
        i_en_rx    <= 1'b0;
        check_sync <= 1'b0;
      end
    end
    @(posedge clk);
    i_en_rx    <= 1'b0;
    check_sync <= 1'b0;
    repeat (4) @(posedge clk);
    model_err_i <= ber_types_pkg::accum_t'(err_i);
    model_err_q <= ber_types_pkg::accum_t'(err_q);
    check_end   <= 1'b1;
    @(posedge clk);
    check_end <= 1'b0;
    i_enable  <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  initial begin
    longint total_ns;
    i_rst_n    <= 1'b0;
    i_enable   <= 1'b0;
    i_en_rx    <= 1'b0;
    i_rx_bit_i <= 1'b0;
    i_rx_bit_q <= 1'b0;
    check_idle <= 1'b0;
    check_end  <= 1'b0;
    check_sync <= 1'b0;
    test_num   <= 0;
    void'($urandom(32'hbdc5bbfa));
    for (int i = 0; i < COLS * MAX_TESTS; i++) begin
      stim[i] = '0;
    end
    $readmemh("verification/ber_stimulus.txt", stim);
    seq_i     = prbs9_sequence(SEED_I);
    seq_q     = prbs9_sequence(SEED_Q);
    num_tests = 0;
    total_ns  = 0;
    // A line with zero count bits ends the test list.
    while (num_tests < MAX_TESTS && stim[num_tests*COLS+2] != 0) begin
      total_ns += (longint'(SYNC_BITS) + longint'(stim[num_tests*COLS+2])) * 4
                  / longint'(stim[num_tests*COLS+5]) * 100;
      num_tests++;
    end
    limit_ns = 2 * total_ns;
    repeat (3) @(posedge clk);
    i_rst_n <= 1'b1;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    if (num_tests == 0) begin
      $display("No tests were found in the stimulus file");
    end
    $display("Summary: %0d tests run, %0d failing, %0d check errors",
             tests_run, tests_failed, check_errors);
    if (num_tests > 0 && tests_run == num_tests && tests_failed == 0 && check_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    wait (limit_ns != 0);
    #(limit_ns);
    $display("Watchdog: the run timed out after %0d ns", limit_ns);
    $display("Test failed");
    $finish;
  end

endmodule

/* verilog/ber_control.sv */
module ber_control
(
  output logic o_phase_sync ,
  output logic o_phase_count,
  output logic o_synced     ,
  input  logic i_enable     ,
  input  logic i_sweep_done ,
  input  logic i_rst_n      ,
  input  logic clk
);

  ber_ctrl_pkg::ber_state_t state;
  ber_ctrl_pkg::ber_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      ber_ctrl_pkg::IDLE: begin
        if (i_enable) begin
          state_next = ber_ctrl_pkg::SYNC;
        end
      end
      ber_ctrl_pkg::SYNC: begin
        if (i_sweep_done) begin
          state_next = ber_ctrl_pkg::COUNT;
        end
      end
      ber_ctrl_pkg::COUNT: begin
        state_next = ber_ctrl_pkg::COUNT;
      end
      default: begin
        state_next = ber_ctrl_pkg::IDLE;
      end
    endcase

    // Dropping the enable aborts the measurement from any state.
    if (!i_enable) begin
      state_next = ber_ctrl_pkg::IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state <= ber_ctrl_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign o_phase_sync  = (state == ber_ctrl_pkg::SYNC);
  assign o_phase_count = (state == ber_ctrl_pkg::COUNT);

  // Lock is declared once the sweep has picked an offset.
  assign o_synced      = (state == ber_ctrl_pkg::COUNT);

endmodule

/* verilog/ber_counter.sv */
module ber_counter #(
  parameter int WINDOW_BITS = ber_types_pkg::PRBS_PERIOD
)
(
  output logic                   o_ber_ok     ,
  output ber_types_pkg::accum_t  o_accum_err  ,
  output ber_types_pkg::accum_t  o_accum_tot  ,
  input  logic                   i_rx_bit     ,
  input  logic                   i_prbs_bit   ,
  input  logic                   i_phase_sync ,
  input  logic                   i_phase_count,
  input  logic                   i_window_done,
  input  ber_types_pkg::offset_t i_offset     ,
  input  logic                   i_en_rx      ,
  input  logic                   i_rst_n      ,
  input  logic                   clk
);

  localparam int HIST_LEN = ber_types_pkg::PRBS_PERIOD - 1;

  // Larger than any window count, so the first window always wins.
  localparam ber_types_pkg::win_cnt_t BEST_INIT = ber_types_pkg::win_cnt_t'(WINDOW_BITS + 1);

  logic [HIST_LEN-1:0]                    hist;
  logic [ber_types_pkg::PRBS_PERIOD-1:0]  taps;
  ber_types_pkg::offset_t                 sel_off;
  ber_types_pkg::offset_t                 best_off;
  ber_types_pkg::win_cnt_t                win_err;
  ber_types_pkg::win_cnt_t                win_sum;
  ber_types_pkg::win_cnt_t                best_err;
  ber_types_pkg::accum_t                  accum_err;
  ber_types_pkg::accum_t                  accum_tot;
  logic                                   active;
  logic                                   ref_bit;
  logic                                   mismatch;

  assign active = i_phase_sync | i_phase_count;

  // Tap 0 is the bit of this strobe, tap j the one produced j strobes earlier.
  assign taps = {hist, i_prbs_bit};

  always_ff @(posedge clk) begin
    if (active && i_en_rx) begin
      hist <= {hist[HIST_LEN-2:0], i_prbs_bit};
    end
  end

  // The sweep probes the timer's offset, counting uses the winner.
  assign sel_off  = i_phase_count ? best_off : i_offset;
  assign ref_bit  = taps[sel_off];
  assign mismatch = i_rx_bit ^ ref_bit;

  // Includes the bit on the closing strobe of the window.
  assign win_sum  = win_err + ber_types_pkg::win_cnt_t'(mismatch);

  always_ff @(posedge clk) begin
    if (!i_rst_n || !i_phase_sync) begin
      win_err <= '0;
    end else if (i_en_rx) begin
      if (i_window_done) begin
        win_err <= '0;
      end else begin
        win_err <= win_sum;
      end
    end
  end

  // Strict compare keeps the lowest offset among equal minima.
  always_ff @(posedge clk) begin
    if (!i_rst_n || !active) begin
      best_err <= BEST_INIT;
      best_off <= '0;
    end else if (i_phase_sync && i_window_done && (win_sum < best_err)) begin
      best_err <= win_sum;
      best_off <= i_offset;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n || !i_phase_count) begin
      accum_err <= '0;
      accum_tot <= '0;
    end else if (i_en_rx) begin
      accum_tot <= accum_tot + 1'b1;
      accum_err <= accum_err + ber_types_pkg::accum_t'(mismatch);
    end
  end

  assign o_accum_err = accum_err;
  assign o_accum_tot = accum_tot;

  // Stays lit through COUNT until the first error lands.
  assign o_ber_ok    = i_phase_count & (accum_err == '0);

endmodule

/* verilog/ber_ctrl_pkg.sv */
package ber_ctrl_pkg;

  localparam int STATE_W = 2;

  // IDLE holds everything cleared, SYNC sweeps the offsets and
  // COUNT accumulates errors at the chosen offset.
  typedef enum logic [STATE_W-1:0] {
    IDLE  = 2'd0,
    SYNC  = 2'd1,
    COUNT = 2'd2
  } ber_state_t;

endpackage

/* verilog/ber_top.sv */
module ber_top #(
  parameter ber_types_pkg::prbs_state_t PRBS_SEED_I = 9'h1AA,
  parameter ber_types_pkg::prbs_state_t PRBS_SEED_Q = 9'h1FE,
  parameter int                         WINDOW_BITS = ber_types_pkg::PRBS_PERIOD
)
(
  output ber_types_pkg::accum_t o_accum_err_i,
  output ber_types_pkg::accum_t o_accum_tot_i,
  output ber_types_pkg::accum_t o_accum_err_q,
  output ber_types_pkg::accum_t o_accum_tot_q,
  output logic                  o_ber_ok_i   ,
  output logic                  o_ber_ok_q   ,
  output logic                  o_synced     ,
  input  logic                  i_rx_bit_i   ,
  input  logic                  i_rx_bit_q   ,
  input  logic                  i_enable     ,
  input  logic                  i_en_rx      ,
  input  logic                  i_rst_n      ,
  input  logic                  clk
);

  logic                   w_phase_sync ;
  logic                   w_phase_count;
  logic                   w_prbs_run   ;
  logic                   w_window_done;
  logic                   w_sweep_done ;
  ber_types_pkg::offset_t w_offset     ;
  logic                   w_prbs_bit_i ;
  logic                   w_prbs_bit_q ;

  ber_control u_ber_control (
    .o_phase_sync (w_phase_sync ),
    .o_phase_count(w_phase_count),
    .o_synced     (o_synced     ),
    .i_enable     (i_enable     ),
    .i_sweep_done (w_sweep_done ),
    .i_rst_n      (i_rst_n      ),
    .clk          (clk          )
  );

  ber_window_timer #(
    .WINDOW_BITS(WINDOW_BITS)
  ) u_ber_window_timer (
    .o_window_done(w_window_done),
    .o_sweep_done (w_sweep_done ),
    .o_offset     (w_offset     ),
    .i_phase_sync (w_phase_sync ),
    .i_en_rx      (i_en_rx      ),
    .i_rst_n      (i_rst_n      ),
    .clk          (clk          )
  );

  // Local generators run through both the sweep and the count.
  assign w_prbs_run = w_phase_sync | w_phase_count;

  prbs9 #(
    .SEED(PRBS_SEED_I)
  ) u_prbs9_i (
    .o_bit  (w_prbs_bit_i),
    .i_run  (w_prbs_run  ),
    .i_en_rx(i_en_rx     ),
    .i_rst_n(i_rst_n     ),
    .clk    (clk         )
  );

  prbs9 #(
    .SEED(PRBS_SEED_Q)
  ) u_prbs9_q (
    .o_bit  (w_prbs_bit_q),
    .i_run  (w_prbs_run  ),
    .i_en_rx(i_en_rx     ),
    .i_rst_n(i_rst_n     ),
    .clk    (clk         )
  );

  ber_counter #(
    .WINDOW_BITS(WINDOW_BITS)
  ) u_ber_counter_i (
    .o_ber_ok     (o_ber_ok_i   ),
    .o_accum_err  (o_accum_err_i),
    .o_accum_tot  (o_accum_tot_i),
    .i_rx_bit     (i_rx_bit_i   ),
    .i_prbs_bit   (w_prbs_bit_i ),
    .i_phase_sync (w_phase_sync ),
    .i_phase_count(w_phase_count),
    .i_window_done(w_window_done),
    .i_offset     (w_offset     ),
    .i_en_rx      (i_en_rx      ),
    .i_rst_n      (i_rst_n      ),
    .clk          (clk          )
  );

  ber_counter #(
    .WINDOW_BITS(WINDOW_BITS)
  ) u_ber_counter_q (
    .o_ber_ok     (o_ber_ok_q   ),
    .o_accum_err  (o_accum_err_q),
    .o_accum_tot  (o_accum_tot_q),
    .i_rx_bit     (i_rx_bit_q   ),
    .i_prbs_bit   (w_prbs_bit_q ),
    .i_phase_sync (w_phase_sync ),
    .i_phase_count(w_phase_count),
    .i_window_done(w_window_done),
    .i_offset     (w_offset     ),
    .i_en_rx      (i_en_rx      ),
    .i_rst_n      (i_rst_n      ),
    .clk          (clk          )
  );

endmodule

/* verilog/ber_types_pkg.sv */
package ber_types_pkg;

  // Order of the PRBS polynomial x^9 + x^5 + 1.
  localparam int PRBS_ORDER = 9;

  // Sequence length. It also sets the window length and the number of offsets.
  localparam int PRBS_PERIOD = (1 << PRBS_ORDER) - 1;

  // Shift state bits that feed the XOR for x^9 and x^5.
  localparam int PRBS_TAP_HI = 8;
  localparam int PRBS_TAP_LO = 4;

  // One bit more than a window needs, so an initial "worse than any" value fits.
  localparam int WIN_CNT_W = 10;

  localparam int ACCUM_W = 64;

  // Shift state of one PRBS9 generator.
  typedef logic [PRBS_ORDER-1:0] prbs_state_t;

  // Candidate or chosen delay between received and local bits, 0 to 510.
  typedef logic [PRBS_ORDER-1:0] offset_t;

  // Bits or errors seen inside one window.
  typedef logic [WIN_CNT_W-1:0] win_cnt_t;

  // Long-running error and total bit counts.
  typedef logic [ACCUM_W-1:0] accum_t;

endpackage

/* verilog/ber_window_timer.sv */
module ber_window_timer #(
  parameter int WINDOW_BITS = ber_types_pkg::PRBS_PERIOD
)
(
  output logic                    o_window_done,
  output logic                    o_sweep_done ,
  output ber_types_pkg::offset_t  o_offset     ,
  input  logic                    i_phase_sync ,
  input  logic                    i_en_rx      ,
  input  logic                    i_rst_n      ,
  input  logic                    clk
);

  localparam ber_types_pkg::win_cnt_t LAST_BIT    = ber_types_pkg::win_cnt_t'(WINDOW_BITS - 1);
  localparam ber_types_pkg::offset_t  LAST_OFFSET =
    ber_types_pkg::offset_t'(ber_types_pkg::PRBS_PERIOD - 1);

  ber_types_pkg::win_cnt_t bit_cnt;
  ber_types_pkg::offset_t  offset;
  logic                    window_end;

  // The strobe carrying the last bit of a window closes it.
  assign window_end = i_phase_sync & i_en_rx & (bit_cnt == LAST_BIT);

  always_ff @(posedge clk) begin
    if (!i_rst_n || !i_phase_sync) begin
      bit_cnt <= '0;
    end else if (i_en_rx) begin
      if (window_end) begin
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // One offset per window, 0 up to 510.
  always_ff @(posedge clk) begin
    if (!i_rst_n || !i_phase_sync) begin
      offset <= '0;
    end else if (window_end) begin
      if (offset == LAST_OFFSET) begin
        offset <= '0;
      end else begin
        offset <= offset + 1'b1;
      end
    end
  end

  assign o_window_done = window_end;
  assign o_sweep_done  = window_end & (offset == LAST_OFFSET);
  assign o_offset      = offset;

endmodule

/* verilog/prbs9.sv */
module prbs9 #(
  parameter ber_types_pkg::prbs_state_t SEED = 9'h1AA
)
(
  output logic o_bit  ,
  input  logic i_run  ,
  input  logic i_en_rx,
  input  logic i_rst_n,
  input  logic clk
);

  ber_types_pkg::prbs_state_t state;
  logic                       feedback;

  assign feedback = state[ber_types_pkg::PRBS_TAP_HI] ^ state[ber_types_pkg::PRBS_TAP_LO];

  // The sequence restarts from the seed whenever no measurement phase is active.
  always_ff @(posedge clk) begin
    if (!i_rst_n || !i_run) begin
      state <= SEED;
    end else if (i_en_rx) begin
      state <= {state[ber_types_pkg::PRBS_ORDER-2:0], feedback};
    end
  end

  // The bit for this strobe is the one about to be shifted in.
  assign o_bit = feedback;

endmodule
